// ==== cd_core_pkg.sv ====
//////////////////////////////////////////////////
// CD core-side types
// Drive command, data-out block, status word, sector header, unpacker states
//////////////////////////////////////////////////
`default_nettype none

package cd_core_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int COMMAND_W = 96;
	localparam int DATAOUT_W = 80;
	localparam int BYTE_W    = 8;
	localparam int DL_WORD_W = 16;
	localparam int LEN_W     = 15;

	// Drive status as reported by the host
	typedef struct packed {
		logic [BYTE_W-1:0] msg;
		logic [BYTE_W-1:0] stat;
	} cd_status_t;

	// 12-byte drive command
	typedef logic [COMMAND_W-1:0] cd_command_t;

	// 10-byte data-out block
	typedef logic [DATAOUT_W-1:0] cd_dataout_t;

	// One sector byte toward the core
	typedef logic [BYTE_W-1:0] cd_byte_t;

	// First word of every sector download
	typedef struct packed {
		logic             data_mode;
		logic [LEN_W-1:0] byte_len;
	} sector_header_t;

	//////////////////////////////////////////////////
	// Sector unpacker FSM
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		UNPACK_HEADER,
		UNPACK_IDLE,
		UNPACK_LOW,
		UNPACK_HIGH
	} unpack_state_e;

endpackage

`default_nettype wire

// ==== cd_host_pkg.sv ====
//////////////////////////////////////////////////
// CD host mailbox definitions
// Word layouts in both directions, request kind codes, counter width
//////////////////////////////////////////////////
`default_nettype none

package cd_host_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int KIND_W      = 15;
	localparam int PAYLOAD_W   = cd_core_pkg::COMMAND_W;
	localparam int HOST_WORD_W = 2 + KIND_W + PAYLOAD_W;
	localparam int COUNT_W     = 8;

	// Bits of the host word above the status fields
	localparam int SPARE_W = HOST_WORD_W - 3 - $bits(cd_core_pkg::cd_status_t);

	// Message kinds toward the host
	typedef enum logic [KIND_W-1:0] {
		KIND_COMMAND  = 15'd0,
		KIND_DATAOUT  = 15'd1,
		KIND_DATA_END = 15'd2,
		KIND_RESET    = 15'd255
	} host_kind_e;

	// Core to host with the toggle on top
	typedef struct packed {
		logic                 toggle;
		logic                 fast_seek;
		host_kind_e           kind;
		logic [PAYLOAD_W-1:0] payload;
	} host_in_t;

	// Host to core
	typedef struct packed {
		logic                   toggle;
		logic [SPARE_W-1:0]     spare;
		logic                   region;
		logic                   dataout_flag;
		cd_core_pkg::cd_status_t status;
	} host_out_t;

	// Message counters
	typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// ==== cd_status_rx.sv ====
//////////////////////////////////////////////////
// CD status receiver
// Picks up host mailbox toggles, delivers status and request pulses
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_status_rx (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  cd_host_pkg::host_out_t  host_out,
	output cd_core_pkg::cd_status_t status,
	output logic                    region,
	output logic                    stat_get,
	output logic                    dataout_req,
	output cd_host_pkg::count_t     stat_cnt
);

	// Host toggle as seen on the previous edge
	logic toggle_last;
	logic new_msg;

	assign new_msg = host_out.toggle != toggle_last;

	// Follows the host even in reset, so a toggle flipped
	// during reset does not show up as a message afterwards
	always_ff @(posedge clk_sys) begin
		toggle_last <= host_out.toggle;
	end

	//////////////////////////////////////////////////
	// Message capture
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		stat_get    <= 1'b0;
		dataout_req <= 1'b0;
		if (reset) begin
			region   <= 1'b0;
			stat_cnt <= '0;
		end else if (new_msg) begin
			region   <= host_out.region;
			stat_cnt <= stat_cnt + 1'b1;
			// Flag chooses which core request fires
			if (host_out.dataout_flag) begin
				dataout_req <= 1'b1;
			end else begin
				stat_get <= 1'b1;
			end
		end
	end

	// Status word itself
	always_ff @(posedge clk_sys) begin
		if (new_msg) begin
			status <= host_out.status;
		end
	end

endmodule

`default_nettype wire

// ==== cd_request_tx.sv ====
//////////////////////////////////////////////////
// CD request transmitter
// Turns rising edges of core requests into mailbox words for the host
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_request_tx (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       comm_send,
	input  wire                       dataout_send,
	input  wire                       data_end,
	input  wire                       reset_req,
	input  cd_core_pkg::cd_command_t  command,
	input  cd_core_pkg::cd_dataout_t  dataout,
	input  wire                       fast_seek,
	output cd_host_pkg::host_in_t     host_in,
	output cd_host_pkg::count_t       comm_cnt
);

	//////////////////////////////////////////////////
	// Edge detection
	//////////////////////////////////////////////////
	logic comm_send_old;
	logic dataout_send_old;
	logic data_end_old;
	logic reset_req_old;

	logic comm_rise;
	logic dataout_rise;
	logic data_end_rise;
	logic reset_rise;

	// Request history tracks the pins through reset too
	always_ff @(posedge clk_sys) begin
		comm_send_old    <= comm_send;
		dataout_send_old <= dataout_send;
		data_end_old     <= data_end;
		reset_req_old    <= reset_req;
	end

	assign comm_rise     = comm_send & ~comm_send_old;
	assign dataout_rise  = dataout_send & ~dataout_send_old;
	assign data_end_rise = data_end & ~data_end_old;
	assign reset_rise    = reset_req & ~reset_req_old;

	//////////////////////////////////////////////////
	// Mailbox word toward the host
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			host_in  <= '0;
			comm_cnt <= '0;
		end else if (comm_rise) begin
			host_in.payload   <= command;
			host_in.fast_seek <= fast_seek;
			host_in.kind      <= cd_host_pkg::KIND_COMMAND;
			host_in.toggle    <= ~host_in.toggle;
			comm_cnt          <= comm_cnt + 1'b1;
		end else if (dataout_rise) begin
			// Block fills the low bytes and the upper command bytes stay
			host_in.payload[cd_core_pkg::DATAOUT_W-1:0] <= dataout;
			host_in.fast_seek <= 1'b0;
			host_in.kind      <= cd_host_pkg::KIND_DATAOUT;
			host_in.toggle    <= ~host_in.toggle;
		end else if (data_end_rise) begin
			host_in.fast_seek <= 1'b0;
			host_in.kind      <= cd_host_pkg::KIND_DATA_END;
			host_in.toggle    <= ~host_in.toggle;
		end else if (reset_rise) begin
			host_in.fast_seek <= 1'b0;
			host_in.kind      <= cd_host_pkg::KIND_RESET;
			host_in.toggle    <= ~host_in.toggle;
		end
	end

	// Lower priority edges in the same cycle are lost
	// since the host only ever sees the latest word

endmodule

`default_nettype wire

// ==== cd_data_unpack.sv ====
//////////////////////////////////////////////////
// CD sector data unpacker
// Reads the sector header, then streams bytes low first with write pulses
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_data_unpack (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire                              dl_active,
	input  wire                              dl_wr,
	input  wire [cd_core_pkg::DL_WORD_W-1:0] dl_data,
	output cd_core_pkg::cd_byte_t            cd_data,
	output logic                             cd_wr,
	output logic                             data_mode
);

	cd_core_pkg::unpack_state_e state;
	cd_core_pkg::sector_header_t hdr;

	logic                              dl_active_old;
	logic                              restart;
	logic                              word_wr;
	logic [cd_core_pkg::LEN_W-1:0]     byte_len;
	logic [cd_core_pkg::LEN_W-1:0]     byte_cnt;
	logic [cd_core_pkg::LEN_W-1:0]     cnt_next;
	logic [cd_core_pkg::DL_WORD_W-1:0] word;

	assign hdr      = cd_core_pkg::sector_header_t'(dl_data);
	assign restart  = dl_active & ~dl_active_old;
	assign word_wr  = dl_wr & dl_active;
	assign cnt_next = byte_cnt + 1'b1;

	// Byte select follows the FSM
	assign cd_data = (state == cd_core_pkg::UNPACK_HIGH) ? word[15:8] : word[7:0];

	always_ff @(posedge clk_sys) begin
		dl_active_old <= dl_active;
	end

	//////////////////////////////////////////////////
	// Unpacker FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= cd_core_pkg::UNPACK_HEADER;
			cd_wr     <= 1'b0;
			byte_cnt  <= '0;
			data_mode <= 1'b0;
		end else if (restart) begin
			// New download so the header comes first again
			state    <= cd_core_pkg::UNPACK_HEADER;
			cd_wr    <= 1'b0;
			byte_cnt <= '0;
		end else begin
			case (state)
				cd_core_pkg::UNPACK_HEADER: begin
					if (word_wr) begin
						data_mode <= hdr.data_mode;
						byte_cnt  <= '0;
						state     <= cd_core_pkg::UNPACK_IDLE;
					end
				end
				cd_core_pkg::UNPACK_IDLE: begin
					// Words past the byte length are dropped
					if (word_wr && byte_cnt < byte_len) begin
						state <= cd_core_pkg::UNPACK_LOW;
					end
				end
				cd_core_pkg::UNPACK_LOW: begin
					if (!cd_wr) begin
						cd_wr <= 1'b1;
					end else begin
						cd_wr    <= 1'b0;
						byte_cnt <= cnt_next;
						// Odd length ends after the low byte
						if (cnt_next >= byte_len) begin
							state <= cd_core_pkg::UNPACK_IDLE;
						end else begin
							state <= cd_core_pkg::UNPACK_HIGH;
						end
					end
				end
				cd_core_pkg::UNPACK_HIGH: begin
					if (!cd_wr) begin
						cd_wr <= 1'b1;
					end else begin
						cd_wr    <= 1'b0;
						byte_cnt <= cnt_next;
						state    <= cd_core_pkg::UNPACK_IDLE;
					end
				end
				default: begin
					state <= cd_core_pkg::UNPACK_HEADER;
				end
			endcase
		end
	end

	// Header length and data word
	always_ff @(posedge clk_sys) begin
		if (state == cd_core_pkg::UNPACK_HEADER && word_wr) begin
			byte_len <= hdr.byte_len;
		end
		if (state == cd_core_pkg::UNPACK_IDLE && word_wr) begin
			word <= dl_data;
		end
	end

endmodule

`default_nettype wire

// ==== cd_link_top.sv ====
//////////////////////////////////////////////////
// CD drive link top level
// Status receiver, request transmitter and sector unpacker
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_link_top (
	input  wire                              clk_sys,
	input  wire                              reset,

	// Host mailbox
	input  cd_host_pkg::host_out_t           host_out,
	output cd_host_pkg::host_in_t            host_in,

	// Core requests
	input  wire                              comm_send,
	input  wire                              dataout_send,
	input  wire                              data_end,
	input  wire                              reset_req,
	input  cd_core_pkg::cd_command_t         command,
	input  cd_core_pkg::cd_dataout_t         dataout,
	input  wire                              fast_seek,

	// Sector download
	input  wire                              dl_active,
	input  wire                              dl_wr,
	input  wire [cd_core_pkg::DL_WORD_W-1:0] dl_data,

	// Toward the core
	output cd_core_pkg::cd_status_t          status,
	output logic                             region,
	output logic                             stat_get,
	output logic                             dataout_req,
	output cd_host_pkg::count_t              stat_cnt,
	output cd_host_pkg::count_t              comm_cnt,
	output cd_core_pkg::cd_byte_t            cd_data,
	output logic                             cd_wr,
	output logic                             data_mode
);

	cd_status_rx u_status_rx (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host_out    (host_out),
		.status      (status),
		.region      (region),
		.stat_get    (stat_get),
		.dataout_req (dataout_req),
		.stat_cnt    (stat_cnt)
	);

	cd_request_tx u_request_tx (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.comm_send    (comm_send),
		.dataout_send (dataout_send),
		.data_end     (data_end),
		.reset_req    (reset_req),
		.command      (command),
		.dataout      (dataout),
		.fast_seek    (fast_seek),
		.host_in      (host_in),
		.comm_cnt     (comm_cnt)
	);

	cd_data_unpack u_data_unpack (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_data   (dl_data),
		.cd_data   (cd_data),
		.cd_wr     (cd_wr),
		.data_mode (data_mode)
	);

endmodule

`default_nettype wire

// ==== cd_link_checker.sv ====
//////////////////////////////////////////////////
// CD link assertions
// Pulse exclusivity, write pulse spacing, toggle origin
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_link_checker (
	input wire                   clk_sys,
	input wire                   reset,
	input wire                   stat_get,
	input wire                   dataout_req,
	input wire                   cd_wr,
	input wire                   comm_send,
	input wire                   dataout_send,
	input wire                   data_end,
	input wire                   reset_req,
	input cd_host_pkg::host_in_t host_in
);

	int         fail_count = 0;
	logic [3:0] req_old;
	logic       rise_any;

	always @(posedge clk_sys) begin
		req_old <= {comm_send, dataout_send, data_end, reset_req};
	end

	// Any request rising on this edge
	assign rise_any = |({comm_send, dataout_send, data_end, reset_req} & ~req_old);

	pulse_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(stat_get && dataout_req))
		else begin
			$error("stat_get and dataout_req high in the same cycle");
			fail_count++;
		end

	write_spacing: assert property (@(posedge clk_sys) disable iff (reset)
		cd_wr |=> !cd_wr)
		else begin
			$error("cd_wr high on two consecutive cycles");
			fail_count++;
		end

	// Toggle moves only after a request edge, or when reset clears it
	toggle_origin: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(host_in.toggle) |-> $past(rise_any) || $past(reset))
		else begin
			$error("host_in.toggle changed without a request edge");
			fail_count++;
		end

endmodule

bind cd_link_top cd_link_checker u_checker (.*);

`default_nettype wire

// ==== cd_link_monitor.sv ====
//////////////////////////////////////////////////
// CD link monitor
// Reference model of the link that compares DUT outputs on every clock
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cd_link_monitor (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  cd_host_pkg::host_out_t   host_out,
	input  wire                      comm_send,
	input  wire                      dataout_send,
	input  wire                      data_end,
	input  wire                      reset_req,
	input  cd_core_pkg::cd_command_t command,
	input  cd_core_pkg::cd_dataout_t dataout,
	input  wire                      fast_seek,
	input  wire                      dl_active,
	input  wire                      dl_wr,
	input  wire [15:0]               dl_data,
	input  cd_host_pkg::host_in_t    host_in,
	input  cd_core_pkg::cd_status_t  status,
	input  wire                      region,
	input  wire                      stat_get,
	input  wire                      dataout_req,
	input  cd_host_pkg::count_t      stat_cnt,
	input  cd_host_pkg::count_t      comm_cnt,
	input  cd_core_pkg::cd_byte_t    cd_data,
	input  wire                      cd_wr,
	input  wire                      data_mode,
	output int                       error_count,
	output int                       check_count,
	output int                       pending
);

	// Expected outputs as registered on the last edge
	cd_host_pkg::host_in_t       exp_host_in;
	cd_core_pkg::cd_status_t     exp_status;
	cd_host_pkg::count_t         exp_stat_cnt;
	cd_host_pkg::count_t         exp_comm_cnt;
	logic                        exp_region;
	logic                        exp_stat_get;
	logic                        exp_dataout_req;
	logic                        exp_mode;

	logic                        primed = 1'b0;
	logic                        status_known = 1'b0;
	logic                        toggle_seen;
	logic [3:0]                  req_old;
	logic [3:0]                  rise;
	cd_core_pkg::sector_header_t hdr;
	logic                        want_header = 1'b1;
	logic                        dl_active_old;
	logic                        wr_due;
	int                          byte_len;
	int                          bytes_sched;
	int                          cyc = 0;

	// Sample edge and value of each expected byte write
	int                          due_q[$];
	cd_core_pkg::cd_byte_t       byte_q[$];

	initial begin
		error_count = 0;
		check_count = 0;
		pending     = 0;
	end

	task automatic check(input logic ok, input string what);
		check_count++;
		if (ok !== 1'b1) begin
			error_count++;
			$display("[ERROR] t=%0t %s", $time, what);
		end
	endtask

	always @(posedge clk_sys) begin
		//////////////////////////////////////////////////
		// Compare what the last edge produced
		//////////////////////////////////////////////////
		if (primed) begin
			check(stat_get === exp_stat_get && dataout_req === exp_dataout_req,
				$sformatf("stat_get/dataout_req %b%b, expected %b%b",
					stat_get, dataout_req, exp_stat_get, exp_dataout_req));
			check(region === exp_region && stat_cnt === exp_stat_cnt,
				$sformatf("region %b stat_cnt %0d, expected %b %0d",
					region, stat_cnt, exp_region, exp_stat_cnt));
			if (status_known) begin
				check(status === exp_status,
					$sformatf("status %h, expected %h", status, exp_status));
			end
			check(host_in === exp_host_in && comm_cnt === exp_comm_cnt,
				$sformatf("host_in %h comm_cnt %0d, expected %h %0d",
					host_in, comm_cnt, exp_host_in, exp_comm_cnt));
			check(data_mode === exp_mode,
				$sformatf("data_mode %b, expected %b", data_mode, exp_mode));
			wr_due = due_q.size() > 0 && due_q[0] == cyc;
			check(cd_wr === wr_due, $sformatf("cd_wr %b, expected %b", cd_wr, wr_due));
			if (wr_due) begin
				check(cd_data === byte_q[0],
					$sformatf("cd_data %h, expected %h", cd_data, byte_q[0]));
				due_q.delete(0);
				byte_q.delete(0);
			end
		end

		// Status receiver
		exp_stat_get    = 1'b0;
		exp_dataout_req = 1'b0;
		if (reset) begin
			exp_region   = 1'b0;
			exp_stat_cnt = '0;
		end else if (host_out.toggle !== toggle_seen) begin
			exp_region      = host_out.region;
			exp_status      = host_out.status;
			exp_stat_cnt    = exp_stat_cnt + 1'b1;
			status_known    = 1'b1;
			exp_dataout_req = host_out.dataout_flag;
			exp_stat_get    = ~host_out.dataout_flag;
		end
		toggle_seen = host_out.toggle;

		// Request transmitter with the command first
		rise = {comm_send, dataout_send, data_end, reset_req} & ~req_old;
		if (reset) begin
			exp_host_in  = '0;
			exp_comm_cnt = '0;
		end else if (rise != 4'b0000) begin
			exp_host_in.toggle    = ~exp_host_in.toggle;
			exp_host_in.fast_seek = 1'b0;
			if (rise[3]) begin
				exp_host_in.kind      = cd_host_pkg::KIND_COMMAND;
				exp_host_in.payload   = command;
				exp_host_in.fast_seek = fast_seek;
				exp_comm_cnt          = exp_comm_cnt + 1'b1;
			end else if (rise[2]) begin
				exp_host_in.kind          = cd_host_pkg::KIND_DATAOUT;
				exp_host_in.payload[79:0] = dataout;
			end else if (rise[1]) begin
				exp_host_in.kind = cd_host_pkg::KIND_DATA_END;
			end else begin
				exp_host_in.kind = cd_host_pkg::KIND_RESET;
			end
		end
		req_old = {comm_send, dataout_send, data_end, reset_req};

		// Sector unpacker
		if (reset || (dl_active && !dl_active_old)) begin
			want_header = 1'b1;
			due_q.delete();
			byte_q.delete();
			if (reset) begin
				exp_mode = 1'b0;
			end
		end else if (dl_wr && dl_active) begin
			if (want_header) begin
				hdr         = dl_data;
				exp_mode    = hdr.data_mode;
				byte_len    = int'(hdr.byte_len);
				bytes_sched = 0;
				want_header = 1'b0;
			end else if (bytes_sched < byte_len) begin
				// Low byte seen two edges on, high byte two more
				due_q.push_back(cyc + 2);
				byte_q.push_back(dl_data[7:0]);
				bytes_sched++;
				if (bytes_sched < byte_len) begin
					due_q.push_back(cyc + 4);
					byte_q.push_back(dl_data[15:8]);
					bytes_sched++;
				end
			end
		end
		dl_active_old = dl_active;

		primed  = primed | reset;
		pending = due_q.size();
		cyc++;
	end

endmodule

`default_nettype wire

// ==== tb_cd_link.sv ====
//////////////////////////////////////////////////
// CD drive link testbench
// LFSR stimulus on falling edges and the result summary
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_cd_link;

	localparam int DRAIN_LIMIT = 100;

	logic                     clk_sys;
	logic                     reset;
	cd_host_pkg::host_out_t   host_out;
	cd_host_pkg::host_in_t    host_in;
	logic                     comm_send;
	logic                     dataout_send;
	logic                     data_end;
	logic                     reset_req;
	cd_core_pkg::cd_command_t command;
	cd_core_pkg::cd_dataout_t dataout;
	logic                     fast_seek;
	logic                     dl_active;
	logic                     dl_wr;
	logic [15:0]              dl_data;
	cd_core_pkg::cd_status_t  status;
	logic                     region;
	logic                     stat_get;
	logic                     dataout_req;
	cd_host_pkg::count_t      stat_cnt;
	cd_host_pkg::count_t      comm_cnt;
	cd_core_pkg::cd_byte_t    cd_data;
	logic                     cd_wr;
	logic                     data_mode;

	int                       error_count;
	int                       check_count;
	int                       pending;
	int                       timeouts;
	logic [31:0]              lfsr;

	cd_link_top uut (.*);

	cd_link_monitor u_monitor (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Galois LFSR stepped once per random bit
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[126:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// Host flips its toggle with a fresh random word
	task automatic send_status();
		logic [127:0] r;
		r = rand_bits(112);
		host_out = {~host_out.toggle, r[111:0]};
		wait_cycles(1 + int'(rand_bits(2)));
	endtask

	task automatic send_request();
		logic [127:0] r;
		r         = rand_bits(96);
		command   = r[95:0];
		r         = rand_bits(83);
		dataout   = r[79:0];
		fast_seek = r[80];
		case (r[82:81])
			2'd0: comm_send = 1'b1;
			2'd1: dataout_send = 1'b1;
			2'd2: data_end = 1'b1;
			default: reset_req = 1'b1;
		endcase
		wait_cycles(1 + int'(rand_bits(1)));
		{comm_send, dataout_send, data_end, reset_req} = 4'b0000;
		wait_cycles(2);
	endtask

	// One strobe followed by at least 5 quiet cycles
	task automatic write_word(input logic [15:0] w);
		dl_data = w;
		dl_wr   = 1'b1;
		wait_cycles(1);
		dl_wr = 1'b0;
		wait_cycles(5 + int'(rand_bits(2)));
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (pending != 0 && t < DRAIN_LIMIT) begin
			@(negedge clk_sys);
			t++;
		end
		if (pending != 0) begin
			$display("Timeout: sector bytes still not written after %0d cycles", DRAIN_LIMIT);
			timeouts++;
		end
	endtask

	task automatic send_sector();
		logic [127:0] r;
		int len;
		r   = rand_bits(16);
		len = 1 + int'(r[4:0]);
		dl_active = 1'b1;
		wait_cycles(2);
		write_word({r[15], 15'(len)});
		// Two extra words past the length
		for (int i = 0; i < (len + 1) / 2 + 2; i++) begin
			r = rand_bits(16);
			write_word(r[15:0]);
		end
		wait_drain();
		dl_active = 1'b0;
		wait_cycles(2);
	endtask

	task automatic reset_mid_traffic();
		logic [127:0] r;
		r = rand_bits(16);
		dl_active = 1'b1;
		wait_cycles(2);
		write_word(16'h0010);
		// Data word, host message and command just ahead of reset
		dl_data         = r[15:0];
		dl_wr           = 1'b1;
		comm_send       = 1'b1;
		host_out.toggle = ~host_out.toggle;
		wait_cycles(1);
		dl_wr     = 1'b0;
		comm_send = 1'b0;
		reset     = 1'b1;
		wait_cycles(3);
		reset     = 1'b0;
		dl_active = 1'b0;
		wait_cycles(2);
	endtask

	initial begin
		reset        = 1'b1;
		host_out     = '0;
		comm_send    = 1'b0;
		dataout_send = 1'b0;
		data_end     = 1'b0;
		reset_req    = 1'b0;
		command      = '0;
		dataout      = '0;
		fast_seek    = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_data      = '0;
		timeouts     = 0;
		lfsr         = 32'hb1857d2d;
		wait_cycles(3);
		reset = 1'b0;
		wait_cycles(2);

		repeat (24) send_status();
		repeat (32) send_request();
		repeat (5) send_sector();
		reset_mid_traffic();
		repeat (6) send_status();
		repeat (8) send_request();
		repeat (2) send_sector();
		wait_cycles(4);

		$display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			check_count, error_count, uut.u_checker.fail_count, timeouts);
		if (error_count == 0 && timeouts == 0 && uut.u_checker.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
cd_core_pkg.sv
cd_host_pkg.sv
cd_status_rx.sv
cd_request_tx.sv
cd_data_unpack.sv
cd_link_top.sv
cd_link_checker.sv
cd_link_monitor.sv
tb_cd_link.sv
